// File: project.f
+incdir+design
design/mlsu_pkg.sv
design/circ_queue_ptr.sv
design/ring_fifo.sv
design/mdeshuffle_unit.sv
design/seq_store.sv
design/mlsu_top.sv
verification/mlsu_assert.sv
verification/mlsu_tb.sv

// File: Makefile
TOP := mlsu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: verification/mlsu_tb.sv
/*
 * Load path top testbench with clock and reset, LFSR data,
 * reorder and mask model, compare tasks and directed tests
 */

`timescale 1ns/1ps

module mlsu_tb import mlsu_pkg::*; ();

  localparam int Timeout = 1000;

  logic           clk_i, rst_ni;
  logic [3:0]     rx_valid_i, rx_ready_o;
  rx_lane_t [3:0] rx_i;
  logic           meta_valid_i, meta_ready_o, mask_valid_i, mask_full_o;
  meta_t          meta_i;
  mask_t          mask_i;
  logic           st_valid_o, st_ready_i;
  st_wr_t         st_o;
  int             n_pass, n_err;
  logic [15:0]    lfsr = 16'd78;

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  mlsu_top i_mlsu_top (.*);

  // ----------------------------------------------------------
  // Stimulus and model
  // ----------------------------------------------------------
  // Fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit
  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < 32; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic rx_lane_t [3:0] rand_lanes();
    rx_lane_t [3:0] d;
    for (int l = 0; l < 4; l++) d[l].data = rand_word();
    return d;
  endfunction

  function automatic meta_t make_meta(input logic [3:0] id, input sew_e sew, input logic vm,
                                      input logic [3:0] cnt);
    meta_t m;
    m.req_id  = id;
    m.sew     = sew;
    m.vm      = vm;
    m.cmt_cnt = cnt;
    return m;
  endfunction

  // Element e of width w sits in lane e mod 4, at offset (e div 4)*w inside it
  function automatic st_wr_t expect_wr(input rx_lane_t [3:0] d, input meta_t m, input mask_t k,
                                       input logic [3:0] beat, input logic last);
    st_wr_t r;
    int     w, e, lane, off;
    w = (m.sew == SEW32) ? 8 : (m.sew == SEW16) ? 4 : 2;
    for (int s = 0; s < 32; s++) begin
      e              = s / w;
      lane           = e % 4;
      off            = (e / 4) * w + s % w;
      r.nb[s*4 +: 4] = d[lane].data[off*4 +: 4];
      r.en[s]        = m.vm | k.bits[lane][off];
    end
    r.req_id = m.req_id;
    r.beat   = beat;
    r.last   = last;
    return r;
  endfunction

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  task automatic compare_field(input string name, input logic [127:0] e, input logic [127:0] g);
    if (g !== e) begin
      $display("Mismatch %s: expected %h got %h", name, e, g);
      n_err++;
    end
  endtask

  task automatic check_wr(input st_wr_t exp, input st_wr_t got);
    int e0;
    e0 = n_err;
    compare_field("st_o.nb", exp.nb, got.nb);
    compare_field("st_o.en", 128'(exp.en), 128'(got.en));
    compare_field("st_o.req_id", 128'(exp.req_id), 128'(got.req_id));
    compare_field("st_o.beat", 128'(exp.beat), 128'(got.beat));
    compare_field("st_o.last", 128'(exp.last), 128'(got.last));
    if (n_err == e0) n_pass++;
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("Mismatch %s: expected %h got %h", name, exp, got);
      n_err++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s within %0d cycles", what, Timeout);
    n_err++;
  endtask

  // ----------------------------------------------------------
  // Bus drivers acting on the falling edge
  // ----------------------------------------------------------
  task automatic send_beat(input rx_lane_t [3:0] d);
    logic [3:0] pend, took;
    int         t;
    rx_i       = d;
    pend       = 4'hF;
    rx_valid_i = pend;
    t          = 0;
    while (pend != 4'h0 && t < Timeout) begin
      took = pend & rx_ready_o;
      @(negedge clk_i);
      pend       = pend & ~took;
      rx_valid_i = pend;
      t++;
    end
    if (pend != 4'h0) report_timeout("lane beat not accepted");
    rx_valid_i = 4'h0;
  endtask

  task automatic push_meta(input meta_t m);
    int t;
    meta_i       = m;
    meta_valid_i = 1'b1;
    t            = 0;
    while (!meta_ready_o && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    if (!meta_ready_o) report_timeout("meta record not accepted");
    @(negedge clk_i);
    meta_valid_i = 1'b0;
  endtask

  task automatic push_mask(input mask_t k);
    int t;
    t = 0;
    while (mask_full_o && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    if (mask_full_o) report_timeout("mask queue stayed full");
    mask_i       = k;
    mask_valid_i = 1'b1;
    @(negedge clk_i);
    mask_valid_i = 1'b0;
  endtask

  task automatic collect_wr(output st_wr_t got);
    int t;
    t = 0;
    while (!(st_valid_o && st_ready_i) && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    if (!(st_valid_o && st_ready_i)) report_timeout("no store write");
    got = st_o;
    @(negedge clk_i);
  endtask

  task automatic end_test(input string name, input int e0);
    $display("%s: %0d errors", name, n_err - e0);
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_reset();
    int e0;
    e0 = n_err;
    for (int l = 0; l < 4; l++) check_bit($sformatf("rx_ready_o[%0d]", l), 1'b1, rx_ready_o[l]);
    check_bit("meta_ready_o", 1'b1, meta_ready_o);
    check_bit("mask_full_o", 1'b0, mask_full_o);
    check_bit("st_valid_o", 1'b0, st_valid_o);
    end_test("reset_state", e0);
  endtask

  task automatic test_unmasked();
    int             e0;
    sew_e           sews [3];
    meta_t          m;
    rx_lane_t [3:0] d;
    st_wr_t         got;
    e0   = n_err;
    sews = '{SEW8, SEW16, SEW32};
    for (int i = 0; i < 3; i++) begin
      m = make_meta(4'(i + 1), sews[i], 1'b1, 4'd0);
      push_meta(m);
      d = rand_lanes();
      send_beat(d);
      collect_wr(got);
      check_wr(expect_wr(d, m, '0, 4'd0, 1'b1), got);
    end
    end_test("unmasked_reorder", e0);
  endtask

  task automatic test_masked();
    int             e0;
    meta_t          m;
    mask_t          k [3];
    rx_lane_t [3:0] d;
    st_wr_t         got;
    e0 = n_err;
    m  = make_meta(4'd4, SEW16, 1'b0, 4'd2);
    push_meta(m);
    for (int b = 0; b < 3; b++) begin
      k[b] = rand_word();
      push_mask(k[b]);
    end
    for (int b = 0; b < 3; b++) begin
      d = rand_lanes();
      send_beat(d);
      collect_wr(got);
      check_wr(expect_wr(d, m, k[b], 4'(b), b == 2), got);
    end
    end_test("masked_beats", e0);
  endtask

  // Full lane buffers must wait for the request record
  task automatic test_wait_meta();
    int             e0;
    meta_t          m;
    rx_lane_t [3:0] d;
    st_wr_t         got;
    e0 = n_err;
    d  = rand_lanes();
    send_beat(d);
    repeat (6) begin
      @(negedge clk_i);
      check_bit("st_valid_o", 1'b0, st_valid_o);
    end
    m = make_meta(4'd7, SEW32, 1'b1, 4'd0);
    push_meta(m);
    collect_wr(got);
    check_wr(expect_wr(d, m, '0, 4'd0, 1'b1), got);
    end_test("wait_for_meta", e0);
  endtask

  task automatic test_backpressure();
    int             e0, t;
    meta_t          ma, mb;
    rx_lane_t [3:0] d [3];
    st_wr_t         exp [3];
    st_wr_t         got;
    e0 = n_err;
    ma = make_meta(4'd5, SEW8, 1'b1, 4'd1);
    mb = make_meta(4'd6, SEW32, 1'b1, 4'd0);
    push_meta(ma);
    push_meta(mb);
    for (int b = 0; b < 3; b++) d[b] = rand_lanes();
    exp[0]     = expect_wr(d[0], ma, '0, 4'd0, 1'b0);
    exp[1]     = expect_wr(d[1], ma, '0, 4'd1, 1'b1);
    exp[2]     = expect_wr(d[2], mb, '0, 4'd0, 1'b1);
    st_ready_i = 1'b0;
    fork
      begin
        for (int b = 0; b < 3; b++) send_beat(d[b]);
      end
      begin
        t = 0;
        while (!st_valid_o && t < Timeout) begin
          @(negedge clk_i);
          t++;
        end
        if (!st_valid_o) report_timeout("no store write under back-pressure");
        // Output frozen on beat 0 while the second beat waits in the lane buffers
        repeat (10) begin
          @(negedge clk_i);
          check_wr(exp[0], st_o);
        end
        check_bit("rx_ready_o all low", 1'b1, rx_ready_o == 4'h0);
        st_ready_i = 1'b1;
        for (int b = 0; b < 3; b++) begin
          collect_wr(got);
          check_wr(exp[b], got);
        end
      end
    join
    end_test("back_pressure", e0);
  endtask

  task automatic test_queue_full();
    int             e0, cnt;
    rx_lane_t [3:0] d;
    st_wr_t         got;
    e0  = n_err;
    cnt = 0;
    while (meta_ready_o && cnt < 8) begin
      meta_i       = make_meta(4'(8 + cnt), SEW16, 1'b1, 4'd0);
      meta_valid_i = 1'b1;
      @(negedge clk_i);
      cnt++;
    end
    meta_valid_i = 1'b0;
    compare_field("meta push count", 128'(4), 128'(cnt));
    for (int i = 0; i < 4; i++) begin
      d = rand_lanes();
      send_beat(d);
      collect_wr(got);
      check_wr(expect_wr(d, make_meta(4'(8 + i), SEW16, 1'b1, 4'd0), '0, 4'd0, 1'b1), got);
    end
    end_test("queue_full", e0);
  endtask

  // ----------------------------------------------------------
  // Sequence
  // ----------------------------------------------------------
  initial begin
    n_pass       = 0;
    n_err        = 0;
    rst_ni       = 1'b0;
    rx_valid_i   = '0;
    rx_i         = '0;
    meta_valid_i = 1'b0;
    meta_i       = '0;
    mask_valid_i = 1'b0;
    mask_i       = '0;
    st_ready_i   = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset();
    st_ready_i = 1'b1;
    test_unmasked();
    test_masked();
    test_wait_meta();
    test_backpressure();
    test_queue_full();
    $display("Checks passed %0d, errors %0d", n_pass, n_err);
    if (n_err == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verification/mlsu_assert.sv
/*
 * Concurrent checks on lane and store handshakes, mask strobes
 * and the output valid after reset, bound into the load path top
 */

`timescale 1ns/1ps

module mlsu_assert import mlsu_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic [3:0] rx_valid_i,
  input logic [3:0] rx_ready_i,
  input logic       mask_valid_i,
  input logic       mask_full_i,
  input logic       st_valid_i,
  input logic       st_ready_i,
  input st_wr_t     st_i
);

  // Lane valid holds until its beat is taken
  for (genvar l = 0; l < 4; l++) begin : g_lane
    lane_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rx_valid_i[l] && !rx_ready_i[l] |=> rx_valid_i[l])
      else $error("Lane %0d valid dropped before its transfer", l);
  end

  // Stalled output keeps valid and payload
  st_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    st_valid_i && !st_ready_i |=> st_valid_i && $stable(st_i))
    else $error("Store output changed while stalled");

  // Strobe into a full mask queue would be lost
  mask_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(mask_valid_i && mask_full_i))
    else $error("Mask strobe while mask queue full");

  st_idle_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !st_valid_i)
    else $error("Store valid high right after reset release");

endmodule

bind mlsu_top mlsu_assert i_mlsu_assert (
  .clk_i, .rst_ni, .rx_valid_i, .rx_ready_i(rx_ready_o), .mask_valid_i,
  .mask_full_i(mask_full_o), .st_valid_i(st_valid_o), .st_ready_i, .st_i(st_o)
);

// File: design/mlsu_top.sv
/*
 * Load path top: meta and mask queues, deshuffle unit, sequential store
 */

`timescale 1ns/1ps
`include "mlsu_macros.svh"

module mlsu_top import mlsu_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Lanes
  input  logic     [`MLSU_NR_LANES-1:0] rx_valid_i,
  output logic     [`MLSU_NR_LANES-1:0] rx_ready_o,
  input  rx_lane_t [`MLSU_NR_LANES-1:0] rx_i,
  // Request meta
  input  logic                          meta_valid_i,
  output logic                          meta_ready_o,
  input  meta_t                         meta_i,
  // Mask strobe
  input  logic                          mask_valid_i,
  input  mask_t                         mask_i,
  output logic                          mask_full_o,
  // Store output
  output logic                          st_valid_o,
  input  logic                          st_ready_i,
  output st_wr_t                        st_o
);

  meta_t    meta_head;
  mask_t    mask_head;
  logic     meta_empty, meta_full, meta_pop;
  logic     mask_empty, mask_pop;
  logic     seq_valid, seq_ready;
  seq_buf_t seq_buf;

  assign meta_ready_o = ~meta_full;

  ring_fifo #(.Depth(`MLSU_INFO_DEPTH), .T(meta_t)) i_meta_fifo (
    .clk_i, .rst_ni, .push_i(meta_valid_i), .pop_i(meta_pop), .data_i(meta_i),
    .data_o(meta_head), .empty_o(meta_empty), .full_o(meta_full)
  );

  // Strobe while full is dropped inside the queue
  ring_fifo #(.Depth(`MLSU_MASK_DEPTH), .T(mask_t)) i_mask_fifo (
    .clk_i, .rst_ni, .push_i(mask_valid_i), .pop_i(mask_pop), .data_i(mask_i),
    .data_o(mask_head), .empty_o(mask_empty), .full_o(mask_full_o)
  );

  mdeshuffle_unit i_mdeshuffle (
    .clk_i, .rst_ni, .rx_valid_i, .rx_ready_o, .rx_i,
    .info_i(meta_head), .info_empty_i(meta_empty), .info_pop_o(meta_pop),
    .mask_i(mask_head), .mask_empty_i(mask_empty), .mask_pop_o(mask_pop),
    .seq_valid_o(seq_valid), .seq_ready_i(seq_ready), .seq_o(seq_buf)
  );

  seq_store i_seq_store (
    .clk_i, .rst_ni, .in_valid_i(seq_valid), .in_ready_o(seq_ready), .in_i(seq_buf),
    .st_valid_o, .st_ready_i, .st_o
  );

endmodule

// File: design/seq_store.sv
/*
 * Output register stage, tags each beat with its request id
 * and its beat index within the request
 */

`timescale 1ns/1ps

module seq_store import mlsu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Committed beat
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  seq_buf_t in_i,

  // Store write output
  output logic     st_valid_o,
  input  logic     st_ready_i,
  output st_wr_t   st_o
);

  logic       load;
  logic [3:0] beat_cnt;

  // Accept when empty or being drained this cycle
  assign in_ready_o = !st_valid_o || st_ready_i;
  assign load       = in_valid_i && in_ready_o;

  // ----------------------------------------------------------
  // Control
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_valid_o <= 1'b0;
      beat_cnt   <= '0;
    end else begin
      if (load) begin
        st_valid_o <= 1'b1;
        // Restart numbering after the last beat
        beat_cnt   <= in_i.last ? 4'd0 : beat_cnt + 1'b1;
      end else if (st_ready_i) begin
        st_valid_o <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Payload, held while st_ready_i is low
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (load) begin
      st_o.nb     <= in_i.nb;
      st_o.en     <= in_i.en;
      st_o.req_id <= in_i.req_id;
      st_o.beat   <= beat_cnt;
      st_o.last   <= in_i.last;
    end
  end

endmodule

// File: design/mdeshuffle_unit.sv
/*
 * Lane shuffle buffers, beat commit control and nibble reordering
 * from lane-interleaved to sequential order with mask merge
 */

`timescale 1ns/1ps
`include "mlsu_macros.svh"

module mdeshuffle_unit import mlsu_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // Lane beats
  input  logic     [`MLSU_NR_LANES-1:0]   rx_valid_i,
  output logic     [`MLSU_NR_LANES-1:0]   rx_ready_o,
  input  rx_lane_t [`MLSU_NR_LANES-1:0]   rx_i,

  // Head of meta queue
  input  meta_t                           info_i,
  input  logic                            info_empty_i,
  output logic                            info_pop_o,

  // Head of mask queue
  input  mask_t                           mask_i,
  input  logic                            mask_empty_i,
  output logic                            mask_pop_o,

  // Towards sequential store
  output logic                            seq_valid_o,
  input  logic                            seq_ready_i,
  output seq_buf_t                        seq_o
);

  // ----------------------------------------------------------
  // State
  // ----------------------------------------------------------
  rx_lane_t [`MLSU_NR_LANES-1:0] shf_buf;
  logic     [`MLSU_NR_LANES-1:0] shf_buf_valid;
  logic                          shf_buf_full;

  // Beat position inside the request at the meta head
  logic [3:0]                    beat_cnt;
  logic                          last_beat;
  logic                          commit;

  // ----------------------------------------------------------
  // Commit control
  // ----------------------------------------------------------
  // Lane can take a beat only while its buffer is empty
  assign rx_ready_o   = ~shf_buf_valid;
  assign shf_buf_full = &shf_buf_valid;

  // Needs all lanes, a request, and a mask unless unmasked
  assign seq_valid_o = shf_buf_full && !info_empty_i && (info_i.vm || !mask_empty_i);
  assign commit      = seq_valid_o && seq_ready_i;

  assign last_beat   = (beat_cnt == info_i.cmt_cnt);

  // One mask record per masked beat
  assign mask_pop_o  = commit && !info_i.vm;
  // Request record leaves with its last beat
  assign info_pop_o  = commit && last_beat;

  // ----------------------------------------------------------
  // Nibble reordering
  // ----------------------------------------------------------
  always_comb begin
    nib_pos_t pos;
    seq_o = '0;
    for (int s = 0; s < NrNibbles; s++) begin
      pos = shf_nibble_idx(5'(s), info_i.sew);
      seq_o.nb[s*4 +: 4] = shf_buf[pos.lane].data[pos.off*4 +: 4];
      // Mask bit taken from the source lane and offset
      seq_o.en[s] = info_i.vm || mask_i.bits[pos.lane][pos.off];
    end
    seq_o.req_id = info_i.req_id;
    seq_o.last   = last_beat;
  end

  // ----------------------------------------------------------
  // Buffer and counter update
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shf_buf_valid <= '0;
      beat_cnt      <= '0;
    end else begin
      // Lane capture
      for (int l = 0; l < `MLSU_NR_LANES; l++) begin
        if (rx_valid_i[l] && rx_ready_o[l]) begin
          shf_buf_valid[l] <= 1'b1;
        end
      end
      // All lanes are full here, so no capture collides with the clear
      if (commit) begin
        shf_buf_valid <= '0;
        if (last_beat) begin
          beat_cnt <= '0;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  // Lane payload
  always_ff @(posedge clk_i) begin
    for (int l = 0; l < `MLSU_NR_LANES; l++) begin
      if (rx_valid_i[l] && rx_ready_o[l]) begin
        shf_buf[l] <= rx_i[l];
      end
    end
  end

endmodule

// File: design/ring_fifo.sv
/*
 * Circular queue of any payload type, built on two lap-flag pointers
 */

`timescale 1ns/1ps

module ring_fifo #(
  parameter int unsigned Depth = 4,
  parameter type         T     = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  logic pop_i,
  input  T     data_i,
  output T     data_o,
  output logic empty_o,
  output logic full_o
);

  T                           mem [Depth];
  logic                       enq_flag, deq_flag;
  logic [$clog2(Depth)-1:0]   enq_val, deq_val;
  logic                       do_push, do_pop;

  // Push while full and pop while empty are ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  circ_queue_ptr #(.Entries(Depth)) i_enq_ptr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .inc_i  (do_push),
    .flag_o (enq_flag),
    .value_o(enq_val)
  );

  circ_queue_ptr #(.Entries(Depth)) i_deq_ptr (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .inc_i  (do_pop),
    .flag_o (deq_flag),
    .value_o(deq_val)
  );

  // Same slot, same lap is empty; same slot, other lap is full
  assign empty_o = (enq_val == deq_val) && (enq_flag == deq_flag);
  assign full_o  = (enq_val == deq_val) && (enq_flag != deq_flag);

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[enq_val] <= data_i;
    end
  end

  assign data_o = mem[deq_val];

endmodule

// File: design/circ_queue_ptr.sv
/*
 * Wrapping queue pointer with a lap flag
 */

`timescale 1ns/1ps

module circ_queue_ptr #(
  parameter  int unsigned Entries = 4,
  localparam int unsigned PtrW    = $clog2(Entries)
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            inc_i,
  output logic            flag_o,
  output logic [PtrW-1:0] value_o
);

  // Flag flips on every wrap so equal values can be told apart
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flag_o  <= 1'b0;
      value_o <= '0;
    end else if (inc_i) begin
      if (value_o == PtrW'(Entries - 1)) begin
        value_o <= '0;
        flag_o  <= ~flag_o;
      end else begin
        value_o <= value_o + 1'b1;
      end
    end
  end

endmodule

// File: design/mlsu_pkg.sv
/*
 * Load path types: element width, lane beat, request meta,
 * mask record, committed beat, store write and the nibble-index rule
 */

`include "mlsu_macros.svh"

package mlsu_pkg;

  localparam int unsigned NrNibbles = `MLSU_NR_LANES * `MLSU_LANE_NIBBLES;

  // Element width, value 3 is illegal
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  // One lane beat
  typedef struct packed {
    logic [`MLSU_LANE_NIBBLES*4-1:0] data;
  } rx_lane_t;

  // Request record
  typedef struct packed {
    logic [3:0] req_id;
    sew_e       sew;
    logic       vm;       // Unmasked request
    logic [3:0] cmt_cnt;  // Beats minus one
  } meta_t;

  // Per-lane nibble masks, lane 0 in the low byte
  typedef struct packed {
    logic [`MLSU_NR_LANES-1:0][`MLSU_LANE_NIBBLES-1:0] bits;
  } mask_t;

  // Beat in sequential order
  typedef struct packed {
    logic [NrNibbles*4-1:0] nb;
    logic [NrNibbles-1:0]   en;
    logic [3:0]             req_id;
    logic                   last;
  } seq_buf_t;

  // Output write record
  typedef struct packed {
    logic [NrNibbles*4-1:0] nb;
    logic [NrNibbles-1:0]   en;
    logic [3:0]             req_id;
    logic [3:0]             beat;
    logic                   last;
  } st_wr_t;

  // Source position of one nibble inside the lane buffers
  typedef struct packed {
    logic [$clog2(`MLSU_NR_LANES)-1:0]     lane;
    logic [$clog2(`MLSU_LANE_NIBBLES)-1:0] off;
  } nib_pos_t;

  // Sequential nibble -> lane and offset, elements dealt round robin over lanes
  function automatic nib_pos_t shf_nibble_idx(input logic [4:0] seq_idx, input sew_e sew);
    int unsigned w;
    int unsigned k;
    int unsigned n;
    nib_pos_t    pos;
    // Element width in nibbles, illegal code treated as SEW8
    case (sew)
      SEW16:   w = 4;
      SEW32:   w = 8;
      default: w = 2;
    endcase
    k = seq_idx / w;
    n = seq_idx % w;
    pos.lane = ($bits(pos.lane))'(k % `MLSU_NR_LANES);
    pos.off  = ($bits(pos.off))'((k / `MLSU_NR_LANES) * w + n);
    return pos;
  endfunction

endpackage

// File: design/mlsu_macros.svh
/*
 * Sizing constants for the matrix load path: lane count,
 * nibbles per lane beat and the depths of the meta and mask queues
 */

`ifndef MLSU_MACROS_SVH
`define MLSU_MACROS_SVH

// Number of lanes feeding the deshuffle stage
`define MLSU_NR_LANES 4

// Nibbles in one 32-bit lane beat
`define MLSU_LANE_NIBBLES 8

// Pending request records
`define MLSU_INFO_DEPTH 4

// Pending mask records, one per beat
`define MLSU_MASK_DEPTH 4

`endif
